// File: build.f
rtl/lm80c_pkg.sv
rtl/lm80c_system_control.sv
rtl/lm80c_io_decoder.sv
rtl/lm80c_memory_arbiter.sv
rtl/lm80c_sysram.sv
rtl/lm80c_led_port.sv
rtl/lm80c_bus_top.sv
bench/lm80c_bus_properties.sv
bench/lm80c_bus_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the bus fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f build.f --top-module lm80c_bus_tb; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vlm80c_bus_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
	exit 0
fi
echo "Pass line not found in simulation output"
exit 1

// File: bench/lm80c_bus_tb.sv
// Bus fabric testbench, CPU and ROM downloader stimulus with RAM and LED models
// Read data and LED checked by assertions against the models
`timescale 1ns/1ps
`default_nettype none

module lm80c_bus_tb;

	logic                ram_clock;
	logic                RESET;
	lm80c_pkg::cpu_bus_t cpu_bus_i;
	lm80c_pkg::cpu_ctl_t cpu_ctl_i;
	lm80c_pkg::dl_req_t  dl_req_i;
	logic                downloading_i;
	logic                rom_done_i;
	logic                reset_key_i;
	logic [7:0]          cpu_din_o;
	logic                cpu_ena_o;
	logic                vdp_ena_o;
	logic                cpu_reset_o;
	logic                cpu_wait_o;
	logic                led_o;

	logic [7:0]  mem_model [65536]; // Expected RAM contents
	logic [15:0] addrs [$];         // Addresses with known contents
	logic [7:0]  led_model;         // Expected LED latch
	logic [7:0]  exp_din;
	logic        chk_din;           // High while read data must be valid
	logic        chk_led;           // Low while a latch write settles
	logic [31:0] rng;

	lm80c_bus_top dut (.*);

	bind lm80c_bus_top lm80c_bus_properties props (
		.ram_clock, .RESET, .rom_done_i, .downloading_i, .reset_key_i,
		.cpu_reset_i(cpu_reset_o), .cpu_wait_i(cpu_wait_o), .cpu_ena_i(cpu_ena_o),
		.vdp_ena_i(vdp_ena_o), .led_i(led_o), .led_q_i(led_q)
	);

	initial begin
		ram_clock = 1'b0;
		forever #20 ram_clock = ~ram_clock; // 40 ns period
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic wait_edges(input int n);
		repeat (n) @(posedge ram_clock);
		#5; // Drive away from the edge
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	task automatic download(input logic [15:0] a, input logic [7:0] d);
		dl_req_i = '{addr: a, data: d, wr: 1'b1};
		wait_edges(2); // Lands on the second edge
		dl_req_i.wr = 1'b0;
		mem_model[a] = d;
		addrs.push_back(a);
	endtask

	// CPU memory or I/O write, held two edges, then settle time for the LED
	task automatic bus_write(input logic io, input logic [15:0] a, input logic [7:0] d);
		chk_led = 1'b0;
		cpu_bus_i = '{addr: a, dout: d, rd: 1'b0, wr: 1'b1};
		cpu_ctl_i = '{mreq: !io, iorq: io};
		wait_edges(2);
		cpu_bus_i.wr = 1'b0;
		cpu_ctl_i = '0;
		wait_edges(3); // Latch, then led_o
		if (io && a[7:0] == 8'hFF)
			led_model = d;
		else if (!io && !downloading_i && a >= 16'h8000 && a <= 16'hBFFF) begin
			mem_model[a] = d; // Only the RAM window takes CPU writes
			addrs.push_back(a);
		end
		chk_led = 1'b1;
	endtask

	// Held read, data checked from the third edge on
	task automatic bus_read(input logic io, input logic [15:0] a, input logic [7:0] want);
		cpu_bus_i = '{addr: a, dout: 8'h00, rd: 1'b1, wr: 1'b0};
		cpu_ctl_i = '{mreq: !io, iorq: io};
		wait_edges(3);
		exp_din = want;
		chk_din = 1'b1;
		wait_edges(2);
		chk_din = 1'b0;
		cpu_bus_i.rd = 1'b0;
		cpu_ctl_i = '0;
	endtask

	assert property (@(posedge ram_clock) disable iff (RESET) chk_din |-> cpu_din_o == exp_din)
		else abort_run($sformatf("MISMATCH cpu_din_o got %h expected %h",
		                         $sampled(cpu_din_o), exp_din));
	assert property (@(posedge ram_clock) disable iff (RESET)
		chk_led |-> led_o == (led_model != 8'h00))
		else abort_run($sformatf("MISMATCH led_o got %h expected %h",
		                         $sampled(led_o), led_model != 8'h00));
	assert property (@(posedge ram_clock)
		cpu_reset_o == (!rom_done_i || reset_key_i) && cpu_wait_o == (!rom_done_i || downloading_i))
		else abort_run("CPU reset or wait level does not follow the boot status");
	assert property (@(posedge ram_clock) RESET |=> !vdp_ena_o && !cpu_ena_o)
		else abort_run("clock enables active during reset");

	initial begin
		int n;
		logic [15:0] a;
		RESET = 1'b1;
		cpu_bus_i = '0;
		cpu_ctl_i = '0;
		dl_req_i = '0;
		downloading_i = 1'b0;
		rom_done_i = 1'b0; // ROM not loaded, CPU held
		reset_key_i = 1'b0;
		rng = 32'h69d6_9966;
		led_model = 8'h00;
		exp_din = 8'h00;
		chk_din = 1'b0;
		chk_led = 1'b1;
		wait_edges(16);
		RESET = 1'b0;
		wait_edges(3);
		rom_done_i = 1'b1;
		reset_key_i = 1'b1; // Key alone resets the CPU
		wait_edges(2);
		reset_key_i = 1'b0;
		for (n = 0; n < 8 && !cpu_ena_o; n++)
			wait_edges(1);
		if (!cpu_ena_o)
			abort_run("cpu_ena_o never rose after reset");

		downloading_i = 1'b1; // Downloader owns the RAM, ROM space too
		download(16'h7FFF, 8'h11);
		download(16'hC000, 8'h22);
		download(16'h8000, 8'h33);
		download(16'hBFFF, 8'h44);
		for (int i = 0; i < 12; i++) begin
			rng = xorshift(rng);
			download(rng[15:0], rng[23:16]);
		end
		bus_write(1'b0, 16'h8000, 8'hE5); // Dropped during a download
		downloading_i = 1'b0;
		bus_write(1'b0, 16'h7FFF, 8'hA1); // Just below the window
		for (int i = 0; i < 12; i++) begin
			rng = xorshift(rng);
			a = (i % 2 == 0) ? (16'h8000 | {2'b00, rng[13:0]}) : addrs[i];
			bus_write(1'b0, a, rng[23:16]);
		end
		foreach (addrs[i])
			bus_read(1'b0, addrs[i], mem_model[addrs[i]]);

		bus_write(1'b1, 16'h12FF, 8'h5A); // High address byte ignored
		bus_read(1'b1, 16'h34FF, 8'h5A);
		rng = xorshift(rng);
		bus_read(1'b1, {8'h00, 1'b0, rng[6:0]}, 8'h00); // Unmapped port
		bus_write(1'b1, 16'h0020, 8'h77);
		bus_read(1'b1, 16'h00FF, 8'h5A);
		bus_write(1'b1, 16'h00FF, 8'h00); // LED off
		bus_write(1'b1, 16'h00FF, 8'h81);
		bus_read(1'b1, 16'h00FF, 8'h81); // Latch and LED set before the reset
		RESET = 1'b1; // Clears latch and LED
		led_model = 8'h00;
		wait_edges(16);
		RESET = 1'b0;
		bus_read(1'b1, 16'h00FF, 8'h00);
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/lm80c_bus_properties.sv
// Bound checks, CPU reset and wait levels, clock-enable period, LED output
`timescale 1ns/1ps
`default_nettype none

module lm80c_bus_properties (
	input logic       ram_clock,
	input logic       RESET,
	input logic       rom_done_i,
	input logic       downloading_i,
	input logic       reset_key_i,
	input logic       cpu_reset_i,
	input logic       cpu_wait_i,
	input logic       cpu_ena_i,
	input logic       vdp_ena_i,
	input logic       led_i,
	input logic [7:0] led_q_i // LED latch
);

	// Boot status to CPU control, combinational
	a_boot: assert property (@(posedge ram_clock) !rom_done_i |-> cpu_reset_i && cpu_wait_i)
		else $error("CPU not held while the ROM is not loaded");
	a_key: assert property (@(posedge ram_clock) reset_key_i |-> cpu_reset_i)
		else $error("reset key did not reset the CPU");
	a_dl: assert property (@(posedge ram_clock) downloading_i |-> cpu_wait_i)
		else $error("CPU not stalled during a download");
	a_run: assert property (@(posedge ram_clock) rom_done_i && !reset_key_i |-> !cpu_reset_i)
		else $error("CPU reset with no cause");
	a_go: assert property (@(posedge ram_clock) rom_done_i && !downloading_i |-> !cpu_wait_i)
		else $error("CPU stalled with no cause");

	// Enables low in reset, vdp every second cycle, cpu every second vdp pulse
	a_rst_ena: assert property (@(posedge ram_clock) RESET |=> !vdp_ena_i && !cpu_ena_i)
		else $error("clock enables active during reset");
	a_vdp_lo: assert property (@(posedge ram_clock) disable iff (RESET) vdp_ena_i |=> !vdp_ena_i)
		else $error("vdp enable high two cycles in a row");
	a_vdp_hi: assert property (@(posedge ram_clock) disable iff (RESET)
		!vdp_ena_i && !$past(RESET) |=> vdp_ena_i) // First low after reset exempt
		else $error("vdp enable low two cycles in a row");
	a_cpu_vdp: assert property (@(posedge ram_clock) disable iff (RESET)
		cpu_ena_i |-> vdp_ena_i)
		else $error("cpu enable outside a vdp phase");
	a_cpu_alt: assert property (@(posedge ram_clock) disable iff (RESET)
		vdp_ena_i && $past(vdp_ena_i, 2) |-> cpu_ena_i != $past(cpu_ena_i, 2))
		else $error("cpu enable not on every fourth cycle");

	// LED follows the latch one edge later
	a_led: assert property (@(posedge ram_clock) disable iff (RESET)
		1'b1 |=> led_i == $past(led_q_i != 8'h00))
		else $error("LED does not match the latch");

endmodule

`default_nettype wire

// File: rtl/lm80c_bus_top.sv
// Bus fabric top, clock enables, decode, RAM arbiter, system RAM, LED port
`timescale 1ns/1ps
`default_nettype none

module lm80c_bus_top #(
	parameter int MEM_AW = lm80c_pkg::ADDR_W // RAM size, full 64K by default
) (
	input  logic                          ram_clock,
	input  logic                          RESET,
	input  lm80c_pkg::cpu_bus_t           cpu_bus_i,
	input  lm80c_pkg::cpu_ctl_t           cpu_ctl_i,
	input  lm80c_pkg::dl_req_t            dl_req_i,
	input  logic                          downloading_i,
	input  logic                          rom_done_i,
	input  logic                          reset_key_i,
	output logic [lm80c_pkg::DATA_W-1:0]  cpu_din_o,
	output logic                          cpu_ena_o,
	output logic                          vdp_ena_o,
	output logic                          cpu_reset_o,
	output logic                          cpu_wait_o,
	output logic                          led_o
);

	lm80c_pkg::cycle_e            cycle;    // Registered cycle type
	lm80c_pkg::dev_e              dev;      // Registered device select
	lm80c_pkg::ram_req_t          ram_req;
	logic [lm80c_pkg::DATA_W-1:0] ram_q;
	logic [lm80c_pkg::DATA_W-1:0] led_q;
	logic [lm80c_pkg::DATA_W-1:0] led_data;

	lm80c_system_control u_sysctl (
		.ram_clock     (ram_clock),
		.RESET         (RESET),
		.rom_done_i    (rom_done_i),
		.downloading_i (downloading_i),
		.reset_key_i   (reset_key_i),
		.cpu_ena_o     (cpu_ena_o),
		.vdp_ena_o     (vdp_ena_o),
		.cpu_reset_o   (cpu_reset_o),
		.cpu_wait_o    (cpu_wait_o)
	);

	lm80c_io_decoder u_dec (
		.ram_clock  (ram_clock),
		.RESET      (RESET),
		.cpu_bus_i  (cpu_bus_i),
		.cpu_ctl_i  (cpu_ctl_i),
		.ram_q_i    (ram_q),
		.led_q_i    (led_q),
		.cycle_o    (cycle),
		.dev_o      (dev),
		.led_data_o (led_data),
		.cpu_din_o  (cpu_din_o)
	);

	// Downloader or CPU onto the RAM port
	lm80c_memory_arbiter #(.MEM_AW(MEM_AW)) u_arb (
		.ram_clock     (ram_clock),
		.RESET         (RESET),
		.downloading_i (downloading_i),
		.dl_req_i      (dl_req_i),
		.cpu_bus_i     (cpu_bus_i),
		.cpu_ctl_i     (cpu_ctl_i),
		.ram_req_o     (ram_req)
	);

	lm80c_sysram #(.MEM_AW(MEM_AW)) u_ram (
		.ram_clock (ram_clock),
		.ram_req_i (ram_req),
		.q_o       (ram_q)
	);

	lm80c_led_port u_led (
		.ram_clock (ram_clock),
		.RESET     (RESET),
		.cycle_i   (cycle),
		.dev_i     (dev),
		.data_i    (led_data),
		.led_q_o   (led_q),
		.led_o     (led_o)
	);

endmodule

`default_nettype wire

// File: rtl/lm80c_led_port.sv
// LED latch at I/O port 8'hFF with readback
`timescale 1ns/1ps
`default_nettype none

module lm80c_led_port (
	input  logic                          ram_clock,
	input  logic                          RESET,
	input  lm80c_pkg::cycle_e             cycle_i,
	input  lm80c_pkg::dev_e               dev_i,
	input  logic [lm80c_pkg::DATA_W-1:0]  data_i,
	output logic [lm80c_pkg::DATA_W-1:0]  led_q_o,
	output logic                          led_o
);

	logic [lm80c_pkg::DATA_W-1:0] latch;
	logic                         sel_wr;

	// Decoded I/O write to the LED port
	assign sel_wr = (cycle_i == lm80c_pkg::CYC_IO_WR) && (dev_i == lm80c_pkg::DEV_LED);

	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			latch <= '0;
			led_o <= 1'b0;
		end else begin
			led_o <= (latch != '0); // One edge behind the latch
			if (sel_wr)
				latch <= data_i;
		end
	end

	assign led_q_o = latch; // Readback path

endmodule

`default_nettype wire

// File: rtl/lm80c_sysram.sv
// Synchronous single-port system RAM, registered read
`timescale 1ns/1ps
`default_nettype none

module lm80c_sysram #(
	parameter int MEM_AW = 16
) (
	input  logic                          ram_clock,
	input  lm80c_pkg::ram_req_t           ram_req_i,
	output logic [lm80c_pkg::DATA_W-1:0]  q_o
);

	logic [lm80c_pkg::DATA_W-1:0] mem [2**MEM_AW]; // 2^MEM_AW bytes
	logic [MEM_AW-1:0]            a;

	assign a = ram_req_i.addr[MEM_AW-1:0];

	// Read returns old byte on a write cycle
	always_ff @(posedge ram_clock) begin
		if (ram_req_i.we)
			mem[a] <= ram_req_i.data;
		q_o <= mem[a];
	end

endmodule

`default_nettype wire

// File: rtl/lm80c_memory_arbiter.sv
// RAM port mux between ROM downloader and CPU
// CPU writes limited to the RAM window
`timescale 1ns/1ps
`default_nettype none

module lm80c_memory_arbiter #(
	parameter int MEM_AW = 16
) (
	input  logic                 ram_clock,
	input  logic                 RESET,
	input  logic                 downloading_i,
	input  lm80c_pkg::dl_req_t   dl_req_i,
	input  lm80c_pkg::cpu_bus_t  cpu_bus_i,
	input  lm80c_pkg::cpu_ctl_t  cpu_ctl_i,
	output lm80c_pkg::ram_req_t  ram_req_o
);

	localparam int AW = lm80c_pkg::ADDR_W;
	localparam int unsigned MASK_INT = (1 << MEM_AW) - 1;
	localparam logic [AW-1:0] AMASK = AW'(MASK_INT); // Folds address onto smaller RAM

	logic in_win;
	logic cpu_we;

	// Window check on the full CPU address
	assign in_win = (cpu_bus_i.addr >= lm80c_pkg::RAM_WIN_LO) &&
	                (cpu_bus_i.addr <= lm80c_pkg::RAM_WIN_HI);
	assign cpu_we = cpu_ctl_i.mreq & cpu_bus_i.wr & in_win; // ROM space read-only for CPU

	always_ff @(posedge ram_clock) begin
		if (downloading_i) begin // Downloader owns the RAM
			ram_req_o.addr <= dl_req_i.addr & AMASK;
			ram_req_o.data <= dl_req_i.data;
		end else begin
			ram_req_o.addr <= cpu_bus_i.addr & AMASK;
			ram_req_o.data <= cpu_bus_i.dout;
		end
		if (RESET)
			ram_req_o.we <= 1'b0;
		else
			ram_req_o.we <= downloading_i ? dl_req_i.wr : cpu_we;
	end

endmodule

`default_nettype wire

// File: rtl/lm80c_io_decoder.sv
// Registered bus cycle and device decode
// CPU read data register with device mux
`timescale 1ns/1ps
`default_nettype none

module lm80c_io_decoder (
	input  logic                               ram_clock,
	input  logic                               RESET,
	input  lm80c_pkg::cpu_bus_t                cpu_bus_i,
	input  lm80c_pkg::cpu_ctl_t                cpu_ctl_i,
	input  logic [lm80c_pkg::DATA_W-1:0]       ram_q_i,   // RAM read byte
	input  logic [lm80c_pkg::DATA_W-1:0]       led_q_i,   // LED latch readback
	output lm80c_pkg::cycle_e                  cycle_o,
	output lm80c_pkg::dev_e                    dev_o,
	output logic [lm80c_pkg::DATA_W-1:0]       led_data_o, // Write data to LED port
	output logic [lm80c_pkg::DATA_W-1:0]       cpu_din_o
);

	lm80c_pkg::cycle_e cyc_d;
	lm80c_pkg::dev_e   dev_d;

	// Memory cycle wins if both qualifiers are up
	always_comb begin
		cyc_d = lm80c_pkg::CYC_IDLE;
		dev_d = lm80c_pkg::DEV_NONE;
		if (cpu_ctl_i.mreq) begin
			dev_d = lm80c_pkg::DEV_RAM;
			if (cpu_bus_i.rd)      cyc_d = lm80c_pkg::CYC_MEM_RD;
			else if (cpu_bus_i.wr) cyc_d = lm80c_pkg::CYC_MEM_WR;
		end else if (cpu_ctl_i.iorq) begin
			if (cpu_bus_i.addr[7:0] == lm80c_pkg::LED_PORT)
				dev_d = lm80c_pkg::DEV_LED; // Only low byte decoded
			if (cpu_bus_i.rd)      cyc_d = lm80c_pkg::CYC_IO_RD;
			else if (cpu_bus_i.wr) cyc_d = lm80c_pkg::CYC_IO_WR;
		end
	end

	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			cycle_o <= lm80c_pkg::CYC_IDLE;
			dev_o   <= lm80c_pkg::DEV_NONE;
		end else begin
			cycle_o <= cyc_d;
			dev_o   <= dev_d;
		end
		led_data_o <= cpu_bus_i.dout; // Aligned with cycle_o
	end

	// Read data, RAM byte lags the decode by one edge
	always_ff @(posedge ram_clock) begin
		if (cycle_o == lm80c_pkg::CYC_MEM_RD || cycle_o == lm80c_pkg::CYC_IO_RD) begin
			case (dev_o)
				lm80c_pkg::DEV_RAM: cpu_din_o <= ram_q_i;
				lm80c_pkg::DEV_LED: cpu_din_o <= led_q_i;
				default:            cpu_din_o <= 8'h00; // Unmapped port
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/lm80c_system_control.sv
// Clock-enable divider for CPU and video phases
// CPU reset and wait levels from boot loader status
`timescale 1ns/1ps
`default_nettype none

module lm80c_system_control (
	input  logic ram_clock,
	input  logic RESET,
	input  logic rom_done_i,    // Boot loader finished
	input  logic downloading_i, // ROM download running
	input  logic reset_key_i,   // Keyboard reset key
	output logic cpu_ena_o,
	output logic vdp_ena_o,
	output logic cpu_reset_o,
	output logic cpu_wait_o
);

	logic [2:0] cnt; // Free running phase counter

	// Enables registered one step ahead of the count
	// so they track even count and count 0 or 4
	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			cnt       <= 3'd0;
			vdp_ena_o <= 1'b0;
			cpu_ena_o <= 1'b0;
		end else begin
			cnt       <= cnt + 3'd1;
			vdp_ena_o <= cnt[0];             // Next count even
			cpu_ena_o <= (cnt[1:0] == 2'b11); // Next count 0 or 4
		end
	end

	// Hold CPU in reset while booting or key pressed
	assign cpu_reset_o = ~rom_done_i | reset_key_i;

	// Stall CPU while booting or downloading
	assign cpu_wait_o = ~rom_done_i | downloading_i;

endmodule

`default_nettype wire

// File: rtl/lm80c_pkg.sv
// Bus structs, cycle and device enums, memory map constants
// Shared by every block of the bus fabric
`default_nettype none

package lm80c_pkg;

	// Bus widths
	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	// CPU writable RAM window, inclusive
	localparam logic [ADDR_W-1:0] RAM_WIN_LO = 16'h8000;
	localparam logic [ADDR_W-1:0] RAM_WIN_HI = 16'hBFFF;

	localparam logic [7:0] LED_PORT = 8'hFF; // Debug LED latch

	// CPU cycle, strobes active high
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] dout; // CPU data out
		logic              rd;
		logic              wr;
	} cpu_bus_t;

	// Cycle qualifiers
	typedef struct packed {
		logic mreq;
		logic iorq;
	} cpu_ctl_t;

	// ROM downloader write port
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic              wr;
	} dl_req_t;

	// What reaches the RAM
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic              we;
	} ram_req_t;

	typedef enum logic [2:0] {
		CYC_IDLE   = 3'd0,
		CYC_MEM_RD = 3'd1,
		CYC_MEM_WR = 3'd2,
		CYC_IO_RD  = 3'd3,
		CYC_IO_WR  = 3'd4
	} cycle_e;

	typedef enum logic [1:0] {
		DEV_NONE = 2'd0,
		DEV_RAM  = 2'd1,
		DEV_LED  = 2'd2
	} dev_e;

endpackage

`default_nettype wire
